// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
TOP ?= tb_periph_soc
RTL_TOP ?= periph_soc
FILELIST ?= periph_soc.f

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		periph_soc_pkg.sv periph_bus_ctrl.sv periph_gpio.sv \
		periph_timer.sv periph_irq_ctrl.sv periph_soc.sv

clean:
	rm -rf obj_dir

// File: periph_bus_ctrl.sv
// Request queue and response path of the register bus
// One access per cycle at most, responses strictly in request order
// The host must respect its request credits; a full queue is overwritten

module periph_bus_ctrl
(
    input logic i_clk,
    input logic i_reset,
    input logic i_req_valid,
    input logic i_req_write,
    input periph_soc_pkg::bus_addr_t i_req_addr,
    input periph_soc_pkg::bus_data_t i_req_wdata,
    output logic o_req_credit,                      // One pulse per popped entry
    output logic o_resp_valid,
    output periph_soc_pkg::bus_data_t o_resp_rdata,
    output logic o_resp_err,
    input logic i_resp_credit,
    output logic o_sel_gpio,
    output logic o_sel_timer,
    output logic o_sel_irq,
    output logic o_wr,
    output periph_soc_pkg::reg_idx_t o_idx,
    output periph_soc_pkg::bus_data_t o_wdata,
    input periph_soc_pkg::bus_data_t i_rdata_gpio,
    input periph_soc_pkg::bus_data_t i_rdata_timer,
    input periph_soc_pkg::bus_data_t i_rdata_irq,
    input logic i_bad_gpio,
    input logic i_bad_timer,
    input logic i_bad_irq
);

logic q_write [periph_soc_pkg::REQ_CREDITS];
periph_soc_pkg::bus_addr_t q_addr [periph_soc_pkg::REQ_CREDITS];
periph_soc_pkg::bus_data_t q_wdata [periph_soc_pkg::REQ_CREDITS];
periph_soc_pkg::qptr_t wr_ptr;
periph_soc_pkg::qptr_t rd_ptr;
periph_soc_pkg::req_cnt_t q_count;
periph_soc_pkg::resp_cnt_t resp_credits;
periph_soc_pkg::bus_addr_t head_addr;
periph_soc_pkg::slot_t head_slot;
periph_soc_pkg::bus_data_t slave_rdata;
logic head_bad;
logic issue;

assign head_addr = q_addr[rd_ptr];
assign head_slot = head_addr[7:6];
assign issue = (q_count != '0) && (resp_credits != '0);

// Head of queue drives the shared slave bus
assign o_wr = q_write[rd_ptr];
assign o_idx = head_addr[5:2];
assign o_wdata = q_wdata[rd_ptr];
assign o_sel_gpio = issue && (head_slot == periph_soc_pkg::SLOT_GPIO);
assign o_sel_timer = issue && (head_slot == periph_soc_pkg::SLOT_TIMER);
assign o_sel_irq = issue && (head_slot == periph_soc_pkg::SLOT_IRQ);

always_comb
begin
    slave_rdata = '0;
    head_bad = 1'b1;                                // Unmapped slot by default
    case (head_slot)
        periph_soc_pkg::SLOT_GPIO:
        begin
            slave_rdata = i_rdata_gpio;
            head_bad = i_bad_gpio;
        end
        periph_soc_pkg::SLOT_TIMER:
        begin
            slave_rdata = i_rdata_timer;
            head_bad = i_bad_timer;
        end
        periph_soc_pkg::SLOT_IRQ:
        begin
            slave_rdata = i_rdata_irq;
            head_bad = i_bad_irq;
        end
        default:
        begin
            slave_rdata = '0;
            head_bad = 1'b1;
        end
    endcase
end

always_ff @(posedge i_clk)
begin
    if (i_req_valid)
    begin
        q_write[wr_ptr] <= i_req_write;
        q_addr[wr_ptr] <= i_req_addr;
        q_wdata[wr_ptr] <= i_req_wdata;
    end
end

always_ff @(posedge i_clk)
begin
    if (i_reset)
    begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        q_count <= '0;
    end
    else
    begin
        if (i_req_valid)
            wr_ptr <= (wr_ptr == periph_soc_pkg::qptr_t'(periph_soc_pkg::REQ_CREDITS - 1))
                      ? '0 : wr_ptr + 1'b1;
        if (issue)
            rd_ptr <= (rd_ptr == periph_soc_pkg::qptr_t'(periph_soc_pkg::REQ_CREDITS - 1))
                      ? '0 : rd_ptr + 1'b1;
        q_count <= q_count + periph_soc_pkg::req_cnt_t'(i_req_valid)
                   - periph_soc_pkg::req_cnt_t'(issue);
    end
end

// Response credits, saturating at the reset grant
always_ff @(posedge i_clk)
begin
    if (i_reset)
        resp_credits <= periph_soc_pkg::resp_cnt_t'(periph_soc_pkg::RESP_CREDITS);
    else if (issue && !i_resp_credit)
        resp_credits <= resp_credits - 1'b1;
    else if (!issue && i_resp_credit &&
             resp_credits != periph_soc_pkg::resp_cnt_t'(periph_soc_pkg::RESP_CREDITS))
        resp_credits <= resp_credits + 1'b1;
end

always_ff @(posedge i_clk)
begin
    if (i_reset)
    begin
        o_resp_valid <= 1'b0;
        o_req_credit <= 1'b0;
    end
    else
    begin
        o_resp_valid <= issue;
        o_req_credit <= issue;
    end
end

always_ff @(posedge i_clk)
begin
    if (issue)
    begin
        o_resp_err <= head_bad;
        if (head_bad)
            o_resp_rdata <= periph_soc_pkg::ERR_DATA;
        else if (o_wr)
            o_resp_rdata <= '0;                     // Writes return zero
        else
            o_resp_rdata <= slave_rdata;
    end
end

endmodule

// File: periph_gpio.sv
// GPIO port with output, direction and rising-edge interrupt registers
// Pins are sampled through two flops, so edges show up 3 cycles late
// Pending bits stay set until software writes 1 to them

module periph_gpio
(
    input logic i_clk,
    input logic i_reset,
    input logic i_sel,
    input logic i_wr,
    input periph_soc_pkg::reg_idx_t i_idx,
    input periph_soc_pkg::bus_data_t i_wdata,
    output periph_soc_pkg::bus_data_t o_rdata,
    output logic o_bad_idx,
    input periph_soc_pkg::gpio_t i_gpio,
    output periph_soc_pkg::gpio_t o_gpio,
    output periph_soc_pkg::gpio_t o_gpio_dir,
    output periph_soc_pkg::gpio_t o_irq
);

periph_soc_pkg::gpio_t gpio_out;
periph_soc_pkg::gpio_t gpio_dir;
periph_soc_pkg::gpio_t gpio_ie;
periph_soc_pkg::gpio_t gpio_ip;
periph_soc_pkg::gpio_t sync_meta;
periph_soc_pkg::gpio_t sync_in;
periph_soc_pkg::gpio_t sync_prev;
periph_soc_pkg::gpio_t rise;
periph_soc_pkg::gpio_t ip_clr;

assign rise = sync_in & ~sync_prev;
assign ip_clr = (i_sel && i_wr && i_idx == periph_soc_pkg::GPIO_IP)
                ? i_wdata[periph_soc_pkg::GPIO_WIDTH-1:0] : '0;

always_comb
begin
    o_bad_idx = 1'b0;
    case (i_idx)
        periph_soc_pkg::GPIO_IN:  o_rdata = periph_soc_pkg::bus_data_t'(sync_in);
        periph_soc_pkg::GPIO_OUT: o_rdata = periph_soc_pkg::bus_data_t'(gpio_out);
        periph_soc_pkg::GPIO_DIR: o_rdata = periph_soc_pkg::bus_data_t'(gpio_dir);
        periph_soc_pkg::GPIO_IE:  o_rdata = periph_soc_pkg::bus_data_t'(gpio_ie);
        periph_soc_pkg::GPIO_IP:  o_rdata = periph_soc_pkg::bus_data_t'(gpio_ip);
        default:
        begin
            o_rdata = '0;
            o_bad_idx = 1'b1;
        end
    endcase
end

always_ff @(posedge i_clk)
begin
    if (i_reset)
    begin
        gpio_out <= '0;
        gpio_dir <= '0;
        gpio_ie <= '0;
        gpio_ip <= '0;
        sync_meta <= '0;
        sync_in <= '0;
        sync_prev <= '0;
    end
    else
    begin
        sync_meta <= i_gpio;
        sync_in <= sync_meta;
        sync_prev <= sync_in;
        gpio_ip <= (gpio_ip & ~ip_clr) | (rise & gpio_ie);  // New edge beats clear
        if (i_sel && i_wr)
        begin
            case (i_idx)
                periph_soc_pkg::GPIO_OUT: gpio_out <= i_wdata[periph_soc_pkg::GPIO_WIDTH-1:0];
                periph_soc_pkg::GPIO_DIR: gpio_dir <= i_wdata[periph_soc_pkg::GPIO_WIDTH-1:0];
                periph_soc_pkg::GPIO_IE:  gpio_ie <= i_wdata[periph_soc_pkg::GPIO_WIDTH-1:0];
                default: ;
            endcase
        end
    end
end

assign o_gpio = gpio_out;
assign o_gpio_dir = gpio_dir;
assign o_irq = gpio_ip;

endmodule

// File: periph_irq_ctrl.sv
// Minimal platform interrupt controller, one context, no priorities
// Sources are level sampled; a still-active source pends again after claim
// Claim is a read with side effect: it clears the returned pending bit

module periph_irq_ctrl
(
    input logic i_clk,
    input logic i_reset,
    input logic i_sel,
    input logic i_wr,
    input periph_soc_pkg::reg_idx_t i_idx,
    input periph_soc_pkg::bus_data_t i_wdata,
    output periph_soc_pkg::bus_data_t o_rdata,
    output logic o_bad_idx,
    input periph_soc_pkg::irq_vec_t i_sources,
    output logic o_meip
);

periph_soc_pkg::irq_vec_t enable;
periph_soc_pkg::irq_vec_t pending;
periph_soc_pkg::irq_vec_t active;
periph_soc_pkg::irq_vec_t claim_clr;
periph_soc_pkg::irq_id_t claim_id;
logic claim_rd;

assign active = pending & enable;
assign claim_rd = i_sel && !i_wr && (i_idx == periph_soc_pkg::IRQ_CLAIM);
assign claim_clr = claim_rd ? (periph_soc_pkg::irq_vec_t'(1) << claim_id) : '0;

// Lowest index wins, source 0 is never reported
always_comb
begin
    claim_id = '0;
    for (int i = periph_soc_pkg::IRQ_TOTAL - 1; i > 0; i--)
    begin
        if (active[i])
            claim_id = periph_soc_pkg::irq_id_t'(i);
    end
end

always_comb
begin
    o_bad_idx = 1'b0;
    case (i_idx)
        periph_soc_pkg::IRQ_ENABLE:  o_rdata = periph_soc_pkg::bus_data_t'(enable);
        periph_soc_pkg::IRQ_PENDING: o_rdata = periph_soc_pkg::bus_data_t'(pending);
        periph_soc_pkg::IRQ_CLAIM:   o_rdata = periph_soc_pkg::bus_data_t'(claim_id);
        default:
        begin
            o_rdata = '0;
            o_bad_idx = 1'b1;
        end
    endcase
end

always_ff @(posedge i_clk)
begin
    if (i_reset)
    begin
        enable <= '0;
        pending <= '0;
    end
    else
    begin
        pending <= (pending | i_sources) & ~claim_clr;
        if (i_sel && i_wr && i_idx == periph_soc_pkg::IRQ_ENABLE)
            enable <= i_wdata[periph_soc_pkg::IRQ_TOTAL-1:0];
    end
end

assign o_meip = |active;

endmodule

// File: periph_soc.f
periph_soc_pkg.sv
periph_bus_ctrl.sv
periph_gpio.sv
periph_timer.sv
periph_irq_ctrl.sv
periph_soc.sv
tb_periph_soc.sv

// File: periph_soc.sv
// Peripheral cluster top: bus controller, GPIO, timer and interrupt controller
// Single clock domain, synchronous active-high reset
// Interrupt sources: 1..12 GPIO pins, 13 external line, 0/14/15 unused

module periph_soc
(
    input logic i_sys_clk,                          // System clock
    input logic i_reset,
    input logic i_req_valid,
    input logic i_req_write,
    input periph_soc_pkg::bus_addr_t i_req_addr,
    input periph_soc_pkg::bus_data_t i_req_wdata,
    output logic o_req_credit,
    output logic o_resp_valid,
    output periph_soc_pkg::bus_data_t o_resp_rdata,
    output logic o_resp_err,
    input logic i_resp_credit,
    input periph_soc_pkg::gpio_t i_gpio,
    output periph_soc_pkg::gpio_t o_gpio,
    output periph_soc_pkg::gpio_t o_gpio_dir,
    input logic i_ext_irq,
    output logic o_mtip,
    output logic o_msip,
    output logic o_meip
);

logic sel_gpio;
logic sel_timer;
logic sel_irq;
logic bus_wr;
periph_soc_pkg::reg_idx_t bus_idx;
periph_soc_pkg::bus_data_t bus_wdata;
periph_soc_pkg::bus_data_t rdata_gpio;
periph_soc_pkg::bus_data_t rdata_timer;
periph_soc_pkg::bus_data_t rdata_irq;
logic bad_gpio;
logic bad_timer;
logic bad_irq;
periph_soc_pkg::gpio_t gpio_irq;
periph_soc_pkg::irq_vec_t irq_sources;

periph_bus_ctrl ctrl0 (
    .i_clk(i_sys_clk),
    .i_reset(i_reset),
    .i_req_valid(i_req_valid),
    .i_req_write(i_req_write),
    .i_req_addr(i_req_addr),
    .i_req_wdata(i_req_wdata),
    .o_req_credit(o_req_credit),
    .o_resp_valid(o_resp_valid),
    .o_resp_rdata(o_resp_rdata),
    .o_resp_err(o_resp_err),
    .i_resp_credit(i_resp_credit),
    .o_sel_gpio(sel_gpio),
    .o_sel_timer(sel_timer),
    .o_sel_irq(sel_irq),
    .o_wr(bus_wr),
    .o_idx(bus_idx),
    .o_wdata(bus_wdata),
    .i_rdata_gpio(rdata_gpio),
    .i_rdata_timer(rdata_timer),
    .i_rdata_irq(rdata_irq),
    .i_bad_gpio(bad_gpio),
    .i_bad_timer(bad_timer),
    .i_bad_irq(bad_irq)
);

periph_gpio gpio0 (
    .i_clk(i_sys_clk),
    .i_reset(i_reset),
    .i_sel(sel_gpio),
    .i_wr(bus_wr),
    .i_idx(bus_idx),
    .i_wdata(bus_wdata),
    .o_rdata(rdata_gpio),
    .o_bad_idx(bad_gpio),
    .i_gpio(i_gpio),
    .o_gpio(o_gpio),
    .o_gpio_dir(o_gpio_dir),
    .o_irq(gpio_irq)
);

periph_timer timer0 (
    .i_clk(i_sys_clk),
    .i_reset(i_reset),
    .i_sel(sel_timer),
    .i_wr(bus_wr),
    .i_idx(bus_idx),
    .i_wdata(bus_wdata),
    .o_rdata(rdata_timer),
    .o_bad_idx(bad_timer),
    .o_mtip(o_mtip),
    .o_msip(o_msip)
);

periph_irq_ctrl irq0 (
    .i_clk(i_sys_clk),
    .i_reset(i_reset),
    .i_sel(sel_irq),
    .i_wr(bus_wr),
    .i_idx(bus_idx),
    .i_wdata(bus_wdata),
    .o_rdata(rdata_irq),
    .o_bad_idx(bad_irq),
    .i_sources(irq_sources),
    .o_meip(o_meip)
);

// Source map
always_comb
begin
    irq_sources = '0;
    irq_sources[periph_soc_pkg::IRQ_GPIO_BASE +: periph_soc_pkg::GPIO_WIDTH] = gpio_irq;
    irq_sources[periph_soc_pkg::IRQ_EXT] = i_ext_irq;
end

endmodule

// File: periph_soc_pkg.sv
// Shared widths, slot map and register offsets of the peripheral cluster
// Word addresses only: bits 7:6 pick the slot, 5:2 the register, 1:0 ignored
// Credit counts must match what the host assumes after reset

package periph_soc_pkg;

    typedef logic [7:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [1:0] slot_t;
    typedef logic [3:0] reg_idx_t;

    localparam int GPIO_WIDTH = 12;
    typedef logic [GPIO_WIDTH-1:0] gpio_t;

    typedef logic [63:0] mtime_t;

    localparam int IRQ_TOTAL = 16;
    typedef logic [IRQ_TOTAL-1:0] irq_vec_t;
    typedef logic [$clog2(IRQ_TOTAL)-1:0] irq_id_t;

    // Flow control
    localparam int REQ_CREDITS = 2;                 // Request queue depth
    localparam int RESP_CREDITS = 2;                // Granted by the host at reset
    typedef logic [$clog2(REQ_CREDITS)-1:0] qptr_t;
    typedef logic [$clog2(REQ_CREDITS+1)-1:0] req_cnt_t;
    typedef logic [$clog2(RESP_CREDITS+1)-1:0] resp_cnt_t;

    // Slots, slot 3 left unmapped
    localparam slot_t SLOT_GPIO = 2'd0;
    localparam slot_t SLOT_TIMER = 2'd1;
    localparam slot_t SLOT_IRQ = 2'd2;

    // GPIO registers
    localparam reg_idx_t GPIO_IN = 4'd0;
    localparam reg_idx_t GPIO_OUT = 4'd1;
    localparam reg_idx_t GPIO_DIR = 4'd2;
    localparam reg_idx_t GPIO_IE = 4'd3;
    localparam reg_idx_t GPIO_IP = 4'd4;            // Write 1 to clear

    // Timer registers
    localparam reg_idx_t TMR_MTIME_LO = 4'd0;
    localparam reg_idx_t TMR_MTIME_HI = 4'd1;
    localparam reg_idx_t TMR_CMP_LO = 4'd2;
    localparam reg_idx_t TMR_CMP_HI = 4'd3;
    localparam reg_idx_t TMR_MSIP = 4'd4;

    // Interrupt controller registers
    localparam reg_idx_t IRQ_ENABLE = 4'd0;
    localparam reg_idx_t IRQ_PENDING = 4'd1;
    localparam reg_idx_t IRQ_CLAIM = 4'd2;

    // Source numbering, 0 means no interrupt
    localparam int IRQ_GPIO_BASE = 1;
    localparam int IRQ_EXT = 13;

    localparam bus_data_t ERR_DATA = 32'hdead_beef;

endpackage

// File: periph_timer.sv
// Core-local timer for a single hart
// mtime is read-only and ticks every clock; compare resets to all ones
// Software updates the 64-bit compare one half at a time

module periph_timer
(
    input logic i_clk,
    input logic i_reset,
    input logic i_sel,
    input logic i_wr,
    input periph_soc_pkg::reg_idx_t i_idx,
    input periph_soc_pkg::bus_data_t i_wdata,
    output periph_soc_pkg::bus_data_t o_rdata,
    output logic o_bad_idx,
    output logic o_mtip,
    output logic o_msip
);

periph_soc_pkg::mtime_t mtime;
periph_soc_pkg::mtime_t mtimecmp;
logic msip;

always_comb
begin
    o_bad_idx = 1'b0;
    case (i_idx)
        periph_soc_pkg::TMR_MTIME_LO: o_rdata = mtime[31:0];
        periph_soc_pkg::TMR_MTIME_HI: o_rdata = mtime[63:32];
        periph_soc_pkg::TMR_CMP_LO:   o_rdata = mtimecmp[31:0];
        periph_soc_pkg::TMR_CMP_HI:   o_rdata = mtimecmp[63:32];
        periph_soc_pkg::TMR_MSIP:     o_rdata = periph_soc_pkg::bus_data_t'(msip);
        default:
        begin
            o_rdata = '0;
            o_bad_idx = 1'b1;
        end
    endcase
end

always_ff @(posedge i_clk)
begin
    if (i_reset)
    begin
        mtime <= '0;
        mtimecmp <= '1;                             // No timer interrupt until set
        msip <= 1'b0;
    end
    else
    begin
        mtime <= mtime + 1'b1;
        if (i_sel && i_wr)
        begin
            case (i_idx)
                periph_soc_pkg::TMR_CMP_LO: mtimecmp[31:0] <= i_wdata;
                periph_soc_pkg::TMR_CMP_HI: mtimecmp[63:32] <= i_wdata;
                periph_soc_pkg::TMR_MSIP:   msip <= i_wdata[0];
                default: ;                          // mtime writes ignored
            endcase
        end
    end
end

assign o_mtip = (mtime >= mtimecmp);
assign o_msip = msip;

endmodule

// File: tb_periph_soc.sv
// Testbench for the peripheral cluster, driven through the host credit channels
// Expected data comes from a register map model, so mtime and claim reads are
// checked by the directed tests and not by the model
// GPIO pins must stay stable during the random mix

module tb_periph_soc;

timeunit 1ns;
timeprecision 100ps;

localparam int CLK_PERIOD = 40;
localparam int N_RANDOM = 300;
localparam int N_DIRECTED = 80;                     // Upper bound, includes mtime polls
localparam int TIMEOUT_CYCLES = (N_RANDOM + N_DIRECTED) * 200 + 500;

logic i_sys_clk;
logic i_reset;
logic i_req_valid;
logic i_req_write;
periph_soc_pkg::bus_addr_t i_req_addr;
periph_soc_pkg::bus_data_t i_req_wdata;
logic o_req_credit;
logic o_resp_valid;
periph_soc_pkg::bus_data_t o_resp_rdata;
logic o_resp_err;
logic i_resp_credit;
periph_soc_pkg::gpio_t i_gpio;
periph_soc_pkg::gpio_t o_gpio;
periph_soc_pkg::gpio_t o_gpio_dir;
logic i_ext_irq;
logic o_mtip;
logic o_msip;
logic o_meip;

// Host bookkeeping
int req_sent;
int req_returned;
int resp_got;
int credits_returned;
logic hold_credits;
logic [31:0] rnd_state;
logic [31:0] credit_state;
periph_soc_pkg::bus_data_t last_rdata;

// Expected responses in request order
periph_soc_pkg::bus_data_t exp_data [$];
logic exp_err [$];
logic exp_chk [$];
string exp_name [$];

// Register map model
periph_soc_pkg::gpio_t m_gpio_in;
periph_soc_pkg::gpio_t m_gpio_out;
periph_soc_pkg::gpio_t m_gpio_dir;
periph_soc_pkg::gpio_t m_gpio_ie;
periph_soc_pkg::gpio_t m_gpio_ip;
periph_soc_pkg::mtime_t m_cmp;
logic m_msip;
periph_soc_pkg::irq_vec_t m_irq_en;

periph_soc periph_soc_inst (
    .i_sys_clk(i_sys_clk),
    .i_reset(i_reset),
    .i_req_valid(i_req_valid),
    .i_req_write(i_req_write),
    .i_req_addr(i_req_addr),
    .i_req_wdata(i_req_wdata),
    .o_req_credit(o_req_credit),
    .o_resp_valid(o_resp_valid),
    .o_resp_rdata(o_resp_rdata),
    .o_resp_err(o_resp_err),
    .i_resp_credit(i_resp_credit),
    .i_gpio(i_gpio),
    .o_gpio(o_gpio),
    .o_gpio_dir(o_gpio_dir),
    .i_ext_irq(i_ext_irq),
    .o_mtip(o_mtip),
    .o_msip(o_msip),
    .o_meip(o_meip)
);

always #(CLK_PERIOD / 2) i_sys_clk = ~i_sys_clk;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic periph_soc_pkg::bus_addr_t make_addr(input periph_soc_pkg::slot_t slot,
                                                         input periph_soc_pkg::reg_idx_t idx);
    return {slot, idx, 2'b00};
endfunction

// Expected response of one access, updates the model state
function automatic void ref_access(input logic wr, input periph_soc_pkg::bus_addr_t addr,
                                   input periph_soc_pkg::bus_data_t wdata,
                                   output periph_soc_pkg::bus_data_t data, output logic err);
    periph_soc_pkg::slot_t slot;
    periph_soc_pkg::reg_idx_t idx;
    periph_soc_pkg::gpio_t wpins;
    slot = addr[7:6];
    idx = addr[5:2];
    wpins = wdata[periph_soc_pkg::GPIO_WIDTH-1:0];
    data = '0;
    err = 1'b0;
    if (slot == periph_soc_pkg::SLOT_GPIO)
    begin
        case (idx)
            periph_soc_pkg::GPIO_IN:  data = 32'(m_gpio_in);
            periph_soc_pkg::GPIO_OUT:
            begin
                data = 32'(m_gpio_out);
                if (wr)
                    m_gpio_out = wpins;
            end
            periph_soc_pkg::GPIO_DIR:
            begin
                data = 32'(m_gpio_dir);
                if (wr)
                    m_gpio_dir = wpins;
            end
            periph_soc_pkg::GPIO_IE:
            begin
                data = 32'(m_gpio_ie);
                if (wr)
                    m_gpio_ie = wpins;
            end
            periph_soc_pkg::GPIO_IP:
            begin
                data = 32'(m_gpio_ip);
                if (wr)
                    m_gpio_ip &= ~wpins;
            end
            default: err = 1'b1;
        endcase
    end
    else if (slot == periph_soc_pkg::SLOT_TIMER)
    begin
        case (idx)
            periph_soc_pkg::TMR_MTIME_LO, periph_soc_pkg::TMR_MTIME_HI: data = '0;
            periph_soc_pkg::TMR_CMP_LO:
            begin
                data = m_cmp[31:0];
                if (wr)
                    m_cmp[31:0] = wdata;
            end
            periph_soc_pkg::TMR_CMP_HI:
            begin
                data = m_cmp[63:32];
                if (wr)
                    m_cmp[63:32] = wdata;
            end
            periph_soc_pkg::TMR_MSIP:
            begin
                data = 32'(m_msip);
                if (wr)
                    m_msip = wdata[0];
            end
            default: err = 1'b1;
        endcase
    end
    else if (slot == periph_soc_pkg::SLOT_IRQ)
    begin
        case (idx)
            periph_soc_pkg::IRQ_ENABLE:
            begin
                data = 32'(m_irq_en);
                if (wr)
                    m_irq_en = wdata[periph_soc_pkg::IRQ_TOTAL-1:0];
            end
            periph_soc_pkg::IRQ_PENDING, periph_soc_pkg::IRQ_CLAIM: data = '0;
            default: err = 1'b1;
        endcase
    end
    else
        err = 1'b1;                                 // Slot 3
    if (err)
        data = periph_soc_pkg::ERR_DATA;
    else if (wr)
        data = '0;
endfunction

task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
endtask

task automatic check_data(input string name, input periph_soc_pkg::bus_data_t exp,
                          input periph_soc_pkg::bus_data_t act);
    if (exp !== act)
        fail_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_err(input string name, input logic exp, input logic act);
    if (exp !== act)
        fail_run($sformatf("error %s err flag: expected %b, actual %b", name, exp, act));
endtask

task automatic check_pins(input string name, input periph_soc_pkg::gpio_t exp,
                          input periph_soc_pkg::gpio_t act);
    if (exp !== act)
        fail_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_irq(input string name, input logic exp, input logic act);
    if (exp !== act)
        fail_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
endtask

// One request, sent once a request credit is free
task automatic send_req(input logic wr, input periph_soc_pkg::bus_addr_t addr,
                        input periph_soc_pkg::bus_data_t wdata, input logic chk,
                        input string name);
    periph_soc_pkg::bus_data_t data;
    logic err;
    @(posedge i_sys_clk);
    while (req_sent - req_returned >= periph_soc_pkg::REQ_CREDITS)
        @(posedge i_sys_clk);
    ref_access(wr, addr, wdata, data, err);
    exp_data.push_back(data);
    exp_err.push_back(err);
    exp_chk.push_back(chk);
    exp_name.push_back(name);
    i_req_valid <= 1'b1;
    i_req_write <= wr;
    i_req_addr <= addr;
    i_req_wdata <= wdata;
    req_sent++;
    @(posedge i_sys_clk);
    i_req_valid <= 1'b0;
endtask

task automatic wait_resp();
    while (resp_got < req_sent)
        @(posedge i_sys_clk);
endtask

task automatic access(input logic wr, input periph_soc_pkg::bus_addr_t addr,
                      input periph_soc_pkg::bus_data_t wdata, input logic chk,
                      input string name);
    send_req(wr, addr, wdata, chk, name);
    wait_resp();
endtask

// Response checker and response credit return
always @(posedge i_sys_clk)
begin : monitor
    string name;
    periph_soc_pkg::bus_data_t d;
    logic e;
    logic c;
    if (i_reset)
        i_resp_credit <= 1'b0;
    else
    begin
        if (o_req_credit)
        begin
            if (req_returned >= req_sent)
                fail_run("request credit returned with no request outstanding");
            req_returned <= req_returned + 1;
        end
        if (o_resp_valid)
        begin
            if (resp_got >= periph_soc_pkg::RESP_CREDITS + credits_returned)
                fail_run("response sent without a response credit");
            else if (exp_data.size() == 0)
                fail_run("response received with no request outstanding");
            else
            begin
                name = exp_name.pop_front();
                d = exp_data.pop_front();
                e = exp_err.pop_front();
                c = exp_chk.pop_front();
                if (c)
                    check_data(name, d, o_resp_rdata);
                check_err(name, e, o_resp_err);
                last_rdata <= o_resp_rdata;
                resp_got <= resp_got + 1;
            end
        end
        credit_state = lcg_next(credit_state);
        if (resp_got > credits_returned && (!hold_credits || credit_state[20:19] == 2'b00))
        begin
            i_resp_credit <= 1'b1;
            credits_returned <= credits_returned + 1;
        end
        else
            i_resp_credit <= 1'b0;
    end
end

initial
begin
    repeat (TIMEOUT_CYCLES) @(posedge i_sys_clk);
    fail_run("timeout: the DUT stopped responding");
end

initial
begin
    periph_soc_pkg::bus_data_t t0;
    periph_soc_pkg::bus_data_t t1;
    periph_soc_pkg::bus_data_t t_cmp;
    periph_soc_pkg::slot_t slot;
    periph_soc_pkg::reg_idx_t idx;
    int polls;
    int k;
    i_sys_clk = 1'b0;
    i_reset = 1'b1;
    i_req_valid = 1'b0;
    i_req_write = 1'b0;
    i_req_addr = '0;
    i_req_wdata = '0;
    i_resp_credit = 1'b0;
    i_gpio = '0;
    i_ext_irq = 1'b0;
    req_sent = 0;
    req_returned = 0;
    resp_got = 0;
    credits_returned = 0;
    hold_credits = 1'b0;
    rnd_state = 32'ha11d;
    credit_state = lcg_next(32'ha11d);
    last_rdata = '0;
    m_gpio_in = '0;
    m_gpio_out = '0;
    m_gpio_dir = '0;
    m_gpio_ie = '0;
    m_gpio_ip = '0;
    m_cmp = '1;
    m_msip = 1'b0;
    m_irq_en = '0;
    repeat (5) @(posedge i_sys_clk);
    i_reset <= 1'b0;
    @(posedge i_sys_clk);
    check_pins("reset gpio", '0, o_gpio);
    check_pins("reset dir", '0, o_gpio_dir);
    check_irq("reset mtip", 1'b0, o_mtip);
    check_irq("reset msip", 1'b0, o_msip);
    check_irq("reset meip", 1'b0, o_meip);
    check_irq("reset req credit", 1'b0, o_req_credit);
    check_irq("reset resp valid", 1'b0, o_resp_valid);

    // GPIO output and direction
    access(1'b1, make_addr(periph_soc_pkg::SLOT_GPIO, periph_soc_pkg::GPIO_OUT), 32'ha5c, 1,
           "wr out");
    access(1'b1, make_addr(periph_soc_pkg::SLOT_GPIO, periph_soc_pkg::GPIO_DIR), 32'h0f0, 1,
           "wr dir");
    access(1'b0, make_addr(periph_soc_pkg::SLOT_GPIO, periph_soc_pkg::GPIO_OUT), '0, 1, "rd out");
    access(1'b0, make_addr(periph_soc_pkg::SLOT_GPIO, periph_soc_pkg::GPIO_DIR), '0, 1, "rd dir");
    check_pins("gpio pins", m_gpio_out, o_gpio);
    check_pins("gpio dir pins", m_gpio_dir, o_gpio_dir);

    // GPIO edge into the interrupt controller
    k = 5;
    access(1'b1, make_addr(periph_soc_pkg::SLOT_GPIO, periph_soc_pkg::GPIO_IE), 32'(1 << k), 1,
           "wr ie");
    i_gpio[k] <= 1'b1;
    repeat (6) @(posedge i_sys_clk);
    i_gpio[k] <= 1'b0;
    m_gpio_ip[k] = 1'b1;
    repeat (4) @(posedge i_sys_clk);
    access(1'b0, make_addr(periph_soc_pkg::SLOT_GPIO, periph_soc_pkg::GPIO_IP), '0, 1, "rd ip");
    check_irq("meip masked", 1'b0, o_meip);
    access(1'b1, make_addr(periph_soc_pkg::SLOT_IRQ, periph_soc_pkg::IRQ_ENABLE),
           32'((1 << (periph_soc_pkg::IRQ_GPIO_BASE + k)) | (1 << periph_soc_pkg::IRQ_EXT)),
           1, "wr irq enable");
    @(posedge i_sys_clk);
    check_irq("meip gpio", 1'b1, o_meip);
    access(1'b1, make_addr(periph_soc_pkg::SLOT_GPIO, periph_soc_pkg::GPIO_IP), 32'(1 << k), 1,
           "clr ip");
    access(1'b0, make_addr(periph_soc_pkg::SLOT_GPIO, periph_soc_pkg::GPIO_IP), '0, 1,
           "rd ip clear");
    access(1'b0, make_addr(periph_soc_pkg::SLOT_IRQ, periph_soc_pkg::IRQ_CLAIM), '0, 0, "claim");
    check_data("claim gpio", 32'(periph_soc_pkg::IRQ_GPIO_BASE + k), last_rdata);
    access(1'b0, make_addr(periph_soc_pkg::SLOT_IRQ, periph_soc_pkg::IRQ_CLAIM), '0, 0, "claim");
    check_data("claim empty", '0, last_rdata);
    check_irq("meip after claim", 1'b0, o_meip);
    i_ext_irq <= 1'b1;
    repeat (2) @(posedge i_sys_clk);
    i_ext_irq <= 1'b0;
    repeat (2) @(posedge i_sys_clk);
    access(1'b0, make_addr(periph_soc_pkg::SLOT_IRQ, periph_soc_pkg::IRQ_CLAIM), '0, 0, "claim");
    check_data("claim ext", 32'(periph_soc_pkg::IRQ_EXT), last_rdata);
    access(1'b0, make_addr(periph_soc_pkg::SLOT_IRQ, periph_soc_pkg::IRQ_CLAIM), '0, 0, "claim");
    check_data("claim ext empty", '0, last_rdata);

    // Timer compare and software interrupt
    access(1'b0, make_addr(periph_soc_pkg::SLOT_TIMER, periph_soc_pkg::TMR_MTIME_LO), '0, 0,
           "mtime");
    t0 = last_rdata;
    access(1'b0, make_addr(periph_soc_pkg::SLOT_TIMER, periph_soc_pkg::TMR_MTIME_LO), '0, 0,
           "mtime");
    t1 = last_rdata;
    if (t1 < t0)
        fail_run("mtime went backwards between two reads");
    t_cmp = t1 + 32'd50;
    access(1'b1, make_addr(periph_soc_pkg::SLOT_TIMER, periph_soc_pkg::TMR_CMP_HI), '0, 1,
           "wr cmp hi");
    access(1'b1, make_addr(periph_soc_pkg::SLOT_TIMER, periph_soc_pkg::TMR_CMP_LO), t_cmp, 1,
           "wr cmp lo");
    check_irq("mtip early", 1'b0, o_mtip);
    polls = 0;
    do
    begin
        access(1'b0, make_addr(periph_soc_pkg::SLOT_TIMER, periph_soc_pkg::TMR_MTIME_LO), '0, 0,
               "mtime poll");
        polls++;
    end
    while (last_rdata < t_cmp && polls < 40);
    if (last_rdata < t_cmp)
        fail_run("mtime never reached the compare value");
    @(posedge i_sys_clk);
    check_irq("mtip late", 1'b1, o_mtip);
    access(1'b1, make_addr(periph_soc_pkg::SLOT_TIMER, periph_soc_pkg::TMR_MSIP), 32'd1, 1,
           "msip set");
    check_irq("msip high", 1'b1, o_msip);
    access(1'b1, make_addr(periph_soc_pkg::SLOT_TIMER, periph_soc_pkg::TMR_MSIP), 32'd0, 1,
           "msip clr");
    check_irq("msip low", 1'b0, o_msip);

    // Error responses
    access(1'b0, make_addr(2'd3, 4'd1), '0, 1, "unmapped slot");
    access(1'b0, make_addr(periph_soc_pkg::SLOT_GPIO, 4'd7), '0, 1, "gpio bad idx");
    access(1'b1, make_addr(periph_soc_pkg::SLOT_TIMER, 4'd9), 32'h1234, 1, "timer bad idx");
    access(1'b0, make_addr(periph_soc_pkg::SLOT_IRQ, 4'd3), '0, 1, "irq bad idx");

    // Random mix with response back-pressure
    hold_credits <= 1'b1;
    for (int n = 0; n < N_RANDOM; n++)
    begin
        rnd_state = lcg_next(rnd_state);
        slot = rnd_state[25:24];
        idx = {1'b0, rnd_state[29:27]};
        // Reads of live timer and claim state are left to the directed tests
        if (!rnd_state[16] && slot == periph_soc_pkg::SLOT_TIMER && idx <= 4'd1)
            idx = periph_soc_pkg::TMR_MSIP;
        if (!rnd_state[16] && slot == periph_soc_pkg::SLOT_IRQ &&
            (idx == periph_soc_pkg::IRQ_PENDING || idx == periph_soc_pkg::IRQ_CLAIM))
            idx = periph_soc_pkg::IRQ_ENABLE;
        send_req(rnd_state[16], make_addr(slot, idx), lcg_next(rnd_state), 1, "random");
    end
    @(posedge i_sys_clk);
    hold_credits <= 1'b0;
    wait_resp();
    repeat (4) @(posedge i_sys_clk);

    if (req_returned != req_sent)
        fail_run("request credits not all returned at the end of the run");
    else
    begin
        $display("TESTS PASSED");
        $finish;
    end
end

endmodule
